//--- hdl/kmcUcodePkg.sv
//////////////////////////////////////////////////////////////////////
// Microword layout for the byte processor control store
// Opcodes outside the enum act as no-ops in the sequencer
// Bit 8 of the microword is unused and ignored by decode
//////////////////////////////////////////////////////////////////////

package kmcUcodePkg;

   // One control-store word
   localparam int ucodeWidth = 16;
   typedef logic [ucodeWidth-1:0] ucodeWord;

   //////////////////////////////////////////////////////////////////////
   // Field positions
   //////////////////////////////////////////////////////////////////////
   localparam int opLsb      = 13;
   localparam int opWidth    = 3;
   localparam int dstLsb     = 11;
   localparam int dstWidth   = 2;
   localparam int marOpLsb   = 9;
   localparam int marOpWidth = 2;
   localparam int immLsb     = 0;
   localparam int immWidth   = 8;

   //////////////////////////////////////////////////////////////////////
   // Field encodings
   //////////////////////////////////////////////////////////////////////
   typedef enum logic [opWidth-1:0]
   {
      opMovImm = 3'd0,
      opMovMem = 3'd1,
      opAddImm = 3'd2,
      opJump   = 3'd3,
      opHalt   = 3'd4
   } ucodeOp;

   typedef enum logic [dstWidth-1:0] {dstNone, dstMem, dstBrg, dstOut} ucodeDst;

   typedef enum logic [marOpWidth-1:0] {marNone, marLdLo, marLdHi, marInc} ucodeMar;

endpackage

//--- hdl/kmcCorePkg.sv
//////////////////////////////////////////////////////////////////////
// Datapath widths and sequencer states
// MAR carries one bit above the 1K RAM address for overflow
//////////////////////////////////////////////////////////////////////

package kmcCorePkg;

   // Data bus
   localparam int dataWidth = 8;
   typedef logic [dataWidth-1:0] dataByte;

   // MAR, 10 address bits plus overflow
   localparam int marBits = 11;
   typedef logic [marBits-1:0] marWord;

   //////////////////////////////////////////////////////////////////////
   // Microsequencer states
   //////////////////////////////////////////////////////////////////////
   typedef enum logic [1:0]
   {
      sIdle,
      sFetch,
      sExec,
      sHalt
   } seqState;

endpackage

//--- hdl/kmcSeq.sv
//////////////////////////////////////////////////////////////////////
// Microsequencer with loadable control store
// Two cycles per microword, fetch then exec
// Control-store writes are taken in any state
// Jump targets wrap modulo the control-store depth
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module kmcSeq
   import kmcUcodePkg::*, kmcCorePkg::*;
#(
   parameter int cramAddrWidth = 6
)
(
   input  logic                     clk,
   input  logic                     rstN,
   input  logic                     init,
   input  logic                     start,
   input  logic                     ucodeWe,
   input  logic [cramAddrWidth-1:0] ucodeAddr,
   input  ucodeWord                 ucodeData,
   output ucodeOp                   op,
   output ucodeDst                  dst,
   output ucodeMar                  marOp,
   output dataByte                  imm,
   output logic                     aluEn,
   output logic                     marClkEn,
   output logic                     memClkEn,
   output logic                     outEn,
   output logic                     done
);

   ucodeWord                 cram [2**cramAddrWidth];
   ucodeWord                 uword;
   logic [cramAddrWidth-1:0] pc;
   seqState                  state;
   logic                     isExec;
   logic                     isMove;
   logic                     isAluOp;

   // Control-store load port
   always_ff @(posedge clk)
   begin
      if (ucodeWe)
         cram[ucodeAddr] <= ucodeData;
   end

   // Microword register, loaded at the end of fetch
   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
         uword <= '0;
      else if (state == sFetch)
         uword <= cram[pc];
   end

   //////////////////////////////////////////////////////////////////////
   // State machine and PC
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
      begin
         state <= sIdle;
         pc    <= '0;
      end
      else if (init)
      begin
         state <= sIdle;
         pc    <= '0;
      end
      else
      begin
         case (state)
            sIdle, sHalt:
               if (start)
               begin
                  state <= sFetch;
                  pc    <= '0;
               end
            sFetch:
               state <= sExec;
            default:
               // Exec, pick the next word
               if (op == opHalt)
                  state <= sHalt;
               else
               begin
                  state <= sFetch;
                  pc    <= (op == opJump) ? cramAddrWidth'(imm) : pc + 1'b1;
               end
         endcase
      end
   end

   // Field split
   assign op    = ucodeOp'(uword[opLsb +: opWidth]);
   assign dst   = ucodeDst'(uword[dstLsb +: dstWidth]);
   assign marOp = ucodeMar'(uword[marOpLsb +: marOpWidth]);
   assign imm   = uword[immLsb +: immWidth];

   //////////////////////////////////////////////////////////////////////
   // Decode into one-cycle enables
   //////////////////////////////////////////////////////////////////////
   assign isExec  = (state == sExec);
   assign isMove  = (op == opMovImm) || (op == opMovMem);
   // ALU result is meaningful
   assign isAluOp = isMove || (op == opAddImm);

   assign memClkEn = isExec && isMove && (dst == dstMem);
   assign aluEn    = isExec && isAluOp && (dst == dstBrg);
   assign outEn    = isExec && isAluOp && (dst == dstOut);
   assign marClkEn = isExec && (marOp != marNone);
   assign done     = (state == sHalt);

endmodule

//--- hdl/kmcAlu.sv
//////////////////////////////////////////////////////////////////////
// ALU with the byte register BRG
// Only pass-immediate, pass-memory and add-immediate are supported
// Adder wraps modulo 256 with no carry out
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module kmcAlu
   import kmcUcodePkg::*, kmcCorePkg::*;
(
   input  logic    clk,
   input  logic    rstN,
   input  logic    init,
   input  ucodeOp  op,
   input  dataByte imm,
   input  dataByte memData,
   input  logic    aluEn,
   output dataByte aluOut
);

   dataByte brg;
   dataByte sum;

   // Adder, BRG plus immediate
   assign sum = brg + imm;

   //////////////////////////////////////////////////////////////////////
   // Source select
   //////////////////////////////////////////////////////////////////////
   always_comb
   begin
      case (op)
         opMovImm: aluOut = imm;
         opMovMem: aluOut = memData;
         opAddImm: aluOut = sum;
         // Jump, halt and no-op words still drive the MAR path
         default:  aluOut = imm;
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // BRG
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
         brg <= '0;
      else if (init)
         brg <= '0;
      else if (aluEn)
         brg <= aluOut;
   end

endmodule

//--- hdl/kmcMem.sv
//////////////////////////////////////////////////////////////////////
// MAR and byte RAM with registered read
// Read data follows the MAR one cycle late, every cycle
// MAR top bit flags overflow after an increment past the last byte
// RAM powers up cleared in simulation
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module kmcMem
   import kmcUcodePkg::*, kmcCorePkg::*;
#(
   parameter int memAddrWidth = 10
)
(
   input  logic    clk,
   input  logic    rstN,
   input  logic    init,
   input  ucodeMar marOp,
   input  logic    marClkEn,
   input  logic    memClkEn,
   input  dataByte aluOut,
   output marWord  mar,
   output dataByte memData
);

   dataByte                 ram [2**memAddrWidth];
   logic [memAddrWidth-9:0] hiBits;

   // High address bits taken from the ALU byte
   assign hiBits = aluOut[memAddrWidth-9:0];

   //////////////////////////////////////////////////////////////////////
   // Memory address register
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
         mar <= '0;
      else if (init)
         mar <= '0;
      else if (marClkEn)
      begin
         case (marOp)
            marLdLo: mar[7:0] <= aluOut;
            // Zero-extended, so overflow clears too
            marLdHi: mar[marBits-1:8] <= (marBits-8)'(hiBits);
            marInc:  mar <= mar + 1'b1;
            default: mar <= mar;
         endcase
      end
   end

   //////////////////////////////////////////////////////////////////////
   // RAM
   //////////////////////////////////////////////////////////////////////
   initial
   begin
      for (int i = 0; i < 2**memAddrWidth; i++)
         ram[i] = '0;
   end

   // Write goes to the MAR as it stood before this edge
   always_ff @(posedge clk)
   begin
      if (memClkEn)
         ram[mar[memAddrWidth-1:0]] <= aluOut;
      memData <= ram[mar[memAddrWidth-1:0]];
   end

endmodule

//--- hdl/kmcOut.sv
//////////////////////////////////////////////////////////////////////
// Output port register
// Strobe is a single cycle with no back-pressure
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module kmcOut
   import kmcCorePkg::*;
(
   input  logic    clk,
   input  logic    rstN,
   input  logic    init,
   input  logic    outEn,
   input  dataByte aluOut,
   output dataByte outData,
   output logic    outStrobe
);

   // Data held until the next output word
   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
      begin
         outData   <= '0;
         outStrobe <= 1'b0;
      end
      else if (init)
      begin
         outData   <= '0;
         outStrobe <= 1'b0;
      end
      else
      begin
         // Strobe lands in the cycle after exec
         outStrobe <= outEn;
         if (outEn)
            outData <= aluOut;
      end
   end

endmodule

//--- hdl/kmcTop.sv
//////////////////////////////////////////////////////////////////////
// Microcoded byte processor top level
// Load the control store, then pulse start; done stays high in halt
// Start is ignored while a program runs
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module kmcTop
   import kmcUcodePkg::*, kmcCorePkg::*;
#(
   parameter int cramAddrWidth = 6,
   parameter int memAddrWidth  = 10
)
(
   input  logic                     clk,
   input  logic                     rstN,
   input  logic                     init,
   input  logic                     ucodeWe,
   input  logic [cramAddrWidth-1:0] ucodeAddr,
   input  ucodeWord                 ucodeData,
   input  logic                     start,
   output logic                     done,
   output dataByte                  outData,
   output logic                     outStrobe,
   output marWord                   mar
);

   // Decoded microword fields
   ucodeOp  op;
   ucodeDst dst;
   ucodeMar marOp;
   dataByte imm;

   // Exec-cycle enables
   logic aluEn;
   logic marClkEn;
   logic memClkEn;
   logic outEn;

   // Datapath buses
   dataByte aluOut;
   dataByte memData;

   //////////////////////////////////////////////////////////////////////
   // Sequencer
   //////////////////////////////////////////////////////////////////////
   kmcSeq #(
      .cramAddrWidth(cramAddrWidth)
   ) i_kmcSeq (
      .clk(clk),           .rstN(rstN),         .init(init),
      .start(start),       .ucodeWe(ucodeWe),   .ucodeAddr(ucodeAddr),
      .ucodeData(ucodeData),
      .op(op),             .dst(dst),           .marOp(marOp),
      .imm(imm),           .aluEn(aluEn),       .marClkEn(marClkEn),
      .memClkEn(memClkEn), .outEn(outEn),       .done(done)
   );

   //////////////////////////////////////////////////////////////////////
   // Datapath
   //////////////////////////////////////////////////////////////////////
   kmcAlu i_kmcAlu (
      .clk(clk),     .rstN(rstN),       .init(init),
      .op(op),       .imm(imm),         .memData(memData),
      .aluEn(aluEn), .aluOut(aluOut)
   );

   kmcMem #(
      .memAddrWidth(memAddrWidth)
   ) i_kmcMem (
      .clk(clk),           .rstN(rstN),         .init(init),
      .marOp(marOp),       .marClkEn(marClkEn), .memClkEn(memClkEn),
      .aluOut(aluOut),     .mar(mar),           .memData(memData)
   );

   kmcOut i_kmcOut (
      .clk(clk),       .rstN(rstN),       .init(init),
      .outEn(outEn),   .aluOut(aluOut),   .outData(outData),
      .outStrobe(outStrobe)
   );

endmodule

//--- testbench/kmcTop_props.sv
//////////////////////////////////////////////////////////////////////
// Concurrent assertions bound into the processor top level
// Sequencer state comes in through the bind connection
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module kmcTopProps
   import kmcUcodePkg::*, kmcCorePkg::*;
(
   input logic    clk,
   input logic    rstN,
   input seqState state,
   input ucodeMar marOp,
   input logic    marClkEn,
   input logic    memClkEn,
   input logic    aluEn,
   input logic    outEn,
   input logic    outStrobe,
   input logic    done,
   input marWord  mar
);

   logic [4:0] strobes;

   assign strobes = {marClkEn, memClkEn, aluEn, outEn, outStrobe};

   // RAM write only in the exec cycle that follows a fetch
   memInExec: assert property (@(posedge clk) disable iff (!rstN)
      memClkEn |-> $past(state) == sFetch)
      else $error("memClkEn high outside exec");

   // No strobe high two cycles running
   singleCycle: assert property (@(posedge clk) disable iff (!rstN)
      (strobes & $past(strobes)) == '0)
      else $error("strobe held longer than one cycle");

   quietWhenDone: assert property (@(posedge clk) disable iff (!rstN)
      done |-> strobes == '0)
      else $error("strobe active while done");

   // Overflow bit only from an increment
   overflowByInc: assert property (@(posedge clk) disable iff (!rstN)
      $rose(mar[10]) |-> $past(marClkEn && marOp == marInc))
      else $error("MAR overflow bit set without an increment");

endmodule

bind kmcTop kmcTopProps i_kmcTopProps (
   .clk(clk),           .rstN(rstN),         .state(i_kmcSeq.state),
   .marOp(marOp),       .marClkEn(marClkEn), .memClkEn(memClkEn),
   .aluEn(aluEn),       .outEn(outEn),       .outStrobe(outStrobe),
   .done(done),         .mar(mar)
);

//--- testbench/kmcTb.sv
//////////////////////////////////////////////////////////////////////
// Directed testbench for the microcoded byte processor
// Every test loads its program from control-store address 0
// Output bytes are collected while outStrobe is high
// RAM is assumed cleared at time zero
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module kmcTb
   import kmcUcodePkg::*, kmcCorePkg::*;
();

   localparam int cramAddrWidth = 6;
   localparam int memAddrWidth  = 10;
   localparam int clkPeriod     = 100;
   localparam int resetCycles   = 8;
   localparam int doneMargin    = 8;
   localparam int maxWords      = 2**cramAddrWidth;
   // Six programs, each a full load plus a full run at worst
   localparam int runCount       = 6;
   localparam int runBudget      = 3*maxWords + doneMargin + 8;
   localparam int watchdogCycles = resetCycles + runCount*runBudget + 16;

   logic                     clk;
   logic                     rstN;
   logic                     init;
   logic                     ucodeWe;
   logic [cramAddrWidth-1:0] ucodeAddr;
   ucodeWord                 ucodeData;
   logic                     start;
   logic                     done;
   dataByte                  outData;
   logic                     outStrobe;
   marWord                   mar;

   int          errorCount;
   int          checkCount;
   logic [31:0] lfsrState = 32'h933c138a;
   ucodeWord    prog [$];
   dataByte     outQ [$];
   dataByte     expQ [$];

   kmcTop #(
      .cramAddrWidth(cramAddrWidth),
      .memAddrWidth(memAddrWidth)
   ) i_kmcTop (
      .clk(clk),             .rstN(rstN),       .init(init),
      .ucodeWe(ucodeWe),     .ucodeAddr(ucodeAddr),
      .ucodeData(ucodeData), .start(start),     .done(done),
      .outData(outData),     .outStrobe(outStrobe),
      .mar(mar)
   );

   // 100 ns clock
   initial
   begin
      clk = 1'b0;
      forever #(clkPeriod/2) clk = ~clk;
   end

   //////////////////////////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////////////////////////
   // Fields op, dst, marOp, spare bit, imm from the top down
   function automatic ucodeWord packWord(ucodeOp o, ucodeDst d, ucodeMar m, dataByte v);
      return {o, d, m, 1'b0, v};
   endfunction

   // Fibonacci LFSR, taps 32 22 2 1
   function automatic logic [31:0] lfsrNext(logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // One LFSR step per bit
   task automatic randByte(output dataByte b);
      b = '0;
      for (int i = 0; i < 8; i++)
      begin
         lfsrState = lfsrNext(lfsrState);
         b = {b[6:0], lfsrState[0]};
      end
   endtask

   task automatic checkEq(input logic [31:0] got, input logic [31:0] exp, input string what);
      checkCount++;
      if (got !== exp)
      begin
         errorCount++;
         $display("CHECK FAILED at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
      end
   endtask

   task automatic loadUcode();
      foreach (prog[i])
      begin
         @(negedge clk);
         ucodeWe   = 1'b1;
         ucodeAddr = cramAddrWidth'(i);
         ucodeData = prog[i];
      end
      @(negedge clk);
      ucodeWe = 1'b0;
   endtask

   // Start pulse, then watch for done
   // Halt word executes on cycle 2n, done follows one cycle later
   task automatic runProgram(input int nExec);
      int cycles;
      int limit;
      limit = 2*nExec + doneMargin;
      outQ.delete();
      @(negedge clk);
      start = 1'b1;
      @(negedge clk);
      start  = 1'b0;
      cycles = 1;
      while (!done && cycles < limit)
      begin
         if (outStrobe)
            outQ.push_back(outData);
         @(negedge clk);
         cycles++;
      end
      if (!done)
      begin
         errorCount++;
         $display("Timeout at %0t: done not raised within %0d cycles", $time, limit);
      end
      else
         checkEq(cycles, 2*nExec + 1, "cycles from start to done");
   endtask

   task automatic compareOut(input string what);
      checkEq(outQ.size(), expQ.size(), {what, " output count"});
      for (int i = 0; i < outQ.size() && i < expQ.size(); i++)
         checkEq(outQ[i], expQ[i], $sformatf("%s output byte %0d", what, i));
   endtask

   //////////////////////////////////////////////////////////////////////
   // Directed tests
   //////////////////////////////////////////////////////////////////////
   task automatic testImmOut();
      dataByte v;
      prog.delete();
      expQ.delete();
      for (int i = 0; i < 4; i++)
      begin
         randByte(v);
         prog.push_back(packWord(opMovImm, dstOut, marNone, v));
         expQ.push_back(v);
      end
      prog.push_back(packWord(opHalt, dstNone, marNone, 8'h00));
      loadUcode();
      runProgram(5);
      compareOut("imm out");
      checkEq(outData, expQ[3], "outData holds last byte");
   endtask

   // Write one byte, read it back, then probe two neighbours
   task automatic testMemRoundTrip();
      dataByte lo;
      dataByte hi;
      dataByte b;
      randByte(lo);
      randByte(hi);
      randByte(b);
      hi = hi & 8'h03;
      prog.delete();
      expQ.delete();
      prog.push_back(packWord(opMovImm, dstNone, marLdLo, lo));
      prog.push_back(packWord(opMovImm, dstNone, marLdHi, hi));
      prog.push_back(packWord(opMovImm, dstMem, marNone, b));
      prog.push_back(packWord(opMovImm, dstNone, marLdLo, lo));
      prog.push_back(packWord(opMovMem, dstOut, marNone, 8'h00));
      prog.push_back(packWord(opMovImm, dstNone, marLdLo, lo ^ 8'h01));
      prog.push_back(packWord(opMovMem, dstOut, marNone, 8'h00));
      prog.push_back(packWord(opMovImm, dstNone, marLdHi, hi ^ 8'h01));
      prog.push_back(packWord(opMovMem, dstOut, marNone, 8'h00));
      prog.push_back(packWord(opHalt, dstNone, marNone, 8'h00));
      expQ.push_back(b);
      expQ.push_back(8'h00);
      expQ.push_back(8'h00);
      loadUcode();
      runProgram(10);
      compareOut("mem round trip");
      checkEq(mar, {1'b0, hi[1:0] ^ 2'b01, lo ^ 8'h01}, "mar after reloads");
   endtask

   // Block write with post-increment, then block read
   task automatic testIncBlock();
      dataByte    lo;
      dataByte    hi;
      dataByte    v;
      logic [9:0] startAddr;
      int         n;
      n = 6;
      randByte(lo);
      randByte(hi);
      // Low half of RAM keeps the block clear of overflow
      hi        = hi & 8'h01;
      startAddr = {hi[1:0], lo};
      prog.delete();
      expQ.delete();
      prog.push_back(packWord(opMovImm, dstNone, marLdLo, lo));
      prog.push_back(packWord(opMovImm, dstNone, marLdHi, hi));
      for (int i = 0; i < n; i++)
      begin
         randByte(v);
         prog.push_back(packWord(opMovImm, dstMem, marInc, v));
         expQ.push_back(v);
      end
      prog.push_back(packWord(opMovImm, dstNone, marLdLo, lo));
      prog.push_back(packWord(opMovImm, dstNone, marLdHi, hi));
      for (int i = 0; i < n; i++)
         prog.push_back(packWord(opMovMem, dstOut, marInc, 8'h00));
      prog.push_back(packWord(opHalt, dstNone, marNone, 8'h00));
      loadUcode();
      runProgram(2*n + 5);
      compareOut("inc block");
      checkEq(mar, {1'b0, startAddr} + n, "mar after block read");
   endtask

   // Running sums in BRG, then a jump over a word
   task automatic testAddJump();
      dataByte base;
      dataByte k;
      dataByte sum;
      randByte(base);
      sum = base;
      prog.delete();
      expQ.delete();
      prog.push_back(packWord(opMovImm, dstBrg, marNone, base));
      for (int i = 0; i < 3; i++)
      begin
         randByte(k);
         sum = sum + k;
         prog.push_back(packWord(opAddImm, dstBrg, marNone, k));
         prog.push_back(packWord(opAddImm, dstOut, marNone, 8'h00));
         expQ.push_back(sum);
      end
      // Target two words ahead, one store depth higher so it wraps
      prog.push_back(packWord(opJump, dstNone, marNone,
                              dataByte'(prog.size() + 2 + maxWords)));
      // Word the jump skips
      prog.push_back(packWord(opMovImm, dstOut, marNone, 8'hee));
      prog.push_back(packWord(opAddImm, dstOut, marNone, 8'h01));
      prog.push_back(packWord(opHalt, dstNone, marNone, 8'h00));
      expQ.push_back(sum + 8'h01);
      loadUcode();
      runProgram(10);
      compareOut("add jump");
   endtask

   task automatic testOverflowInit();
      dataByte r;
      dataByte k;
      randByte(r);
      // Nonzero BRG so the init clear is visible
      r = r | 8'h01;
      prog.delete();
      expQ.delete();
      prog.push_back(packWord(opMovImm, dstBrg, marNone, r));
      prog.push_back(packWord(opMovImm, dstNone, marLdLo, 8'hff));
      prog.push_back(packWord(opMovImm, dstNone, marLdHi, 8'h03));
      prog.push_back(packWord(opMovImm, dstNone, marInc, 8'h00));
      prog.push_back(packWord(opHalt, dstNone, marNone, 8'h00));
      loadUcode();
      runProgram(5);
      // No output words in this program
      compareOut("overflow");
      checkEq(mar, 11'h400, "mar after increment from 1023");
      @(negedge clk);
      init = 1'b1;
      @(negedge clk);
      init = 1'b0;
      checkEq(mar, 0, "mar after init");
      checkEq(done, 0, "done after init");
      checkEq(outData, 0, "outData after init");
      // BRG cleared, so the sum is the immediate alone
      randByte(k);
      prog.delete();
      prog.push_back(packWord(opAddImm, dstOut, marNone, k));
      prog.push_back(packWord(opHalt, dstNone, marNone, 8'h00));
      expQ.push_back(k);
      loadUcode();
      runProgram(2);
      compareOut("after init");
   endtask

   //////////////////////////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////////////////////////
   initial
   begin
      rstN       = 1'b0;
      init       = 1'b0;
      start      = 1'b0;
      ucodeWe    = 1'b0;
      ucodeAddr  = '0;
      ucodeData  = '0;
      errorCount = 0;
      checkCount = 0;
      repeat (resetCycles) @(negedge clk);
      rstN = 1'b1;
      // Reset values
      checkEq(mar, 0, "mar after reset");
      checkEq(done, 0, "done after reset");
      checkEq(outData, 0, "outData after reset");
      checkEq(outStrobe, 0, "outStrobe after reset");
      testImmOut();
      testMemRoundTrip();
      testIncBlock();
      testAddJump();
      testOverflowInit();
      $display("Summary: %0d checks, %0d errors", checkCount, errorCount);
      if (errorCount == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

   // Watchdog
   initial
   begin
      #(watchdogCycles * clkPeriod);
      $display("Watchdog expired after %0d cycles, the run did not finish", watchdogCycles);
      $display("Checks failed");
      $finish;
   end

endmodule

//--- kmcProc.f
hdl/kmcUcodePkg.sv
hdl/kmcCorePkg.sv
hdl/kmcSeq.sv
hdl/kmcAlu.sv
hdl/kmcMem.sv
hdl/kmcOut.sv
hdl/kmcTop.sv
testbench/kmcTop_props.sv
testbench/kmcTb.sv

//--- run.sh
#!/usr/bin/env bash
# Compile the byte processor testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module kmcTb \
   -f kmcProc.f -o kmcSim

simOut=$(./obj_dir/kmcSim 2>&1) || true
echo "$simOut"

if grep -qx "All checks passed" <<< "$simOut"; then
   exit 0
fi
exit 1
